/* Bender.yml */
package:
  name: riscv_mmu

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/mmu_pkg.sv
      - mmu/mmu_tlb.sv
      - mmu/mmu_satp_regs.sv
      - mmu/riscv_mmu.sv
      - src/mmu_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - verif/tb_mem_model.sv
      - verif/tb_mmu_top.sv

/* common/mmu_defines.svh */
`ifndef MMU_DEFINES_SVH
`define MMU_DEFINES_SVH

//////////////////////////////////////////////////
// Address and data widths
//////////////////////////////////////////////////

// Virtual address and data width, RV32
`define MMU_XLEN 32

// Physical address width for Sv32
`define MMU_PLEN 34

//////////////////////////////////////////////////
// Translation sizes
//////////////////////////////////////////////////

// Entries in the fully associative TLB
`define MMU_TLB_ENTRIES 4

// 4 KiB page offset
`define MMU_PAGE_BITS 12

`endif

/* common/mmu_pkg.sv */
package mmu_pkg;

  `include "mmu_defines.svh"

  //////////////////////////////////////////////////
  // Bus side types
  //////////////////////////////////////////////////

  // Access size, same coding on CPU and memory side
  typedef enum logic [1:0] {
    SIZE_BYTE  = 2'b00,
    SIZE_HWORD = 2'b01,
    SIZE_WORD  = 2'b10
  } biu_size_t;

  // CPU request, virtual address
  typedef struct packed {
    logic [`MMU_XLEN-1:0] adr;
    biu_size_t            size;
    logic                 lock;
    logic                 we;
    logic [`MMU_XLEN-1:0] d;
  } vm_req_t;

  // Memory request, physical address
  typedef struct packed {
    logic [`MMU_PLEN-1:0] adr;
    biu_size_t            size;
    logic                 lock;
    logic                 we;
    logic [`MMU_XLEN-1:0] d;
  } pm_req_t;

  //////////////////////////////////////////////////
  // Translation types
  //////////////////////////////////////////////////

  // RV32 satp, mode 0 is bare and mode 1 is Sv32
  typedef struct packed {
    logic        mode;
    logic [8:0]  asid;
    logic [21:0] ppn;
  } satp_t;

  // Sv32 page table entry
  typedef struct packed {
    logic [11:0] ppn1;
    logic [9:0]  ppn0;
    logic [1:0]  rsw;
    logic        d;
    logic        a;
    logic        g;
    logic        u;
    logic        x;
    logic        w;
    logic        r;
    logic        v;
  } pte_t;

  // Cached translation
  // Writable only when both W and D were set in the PTE
  typedef struct packed {
    logic                                valid;
    logic [`MMU_XLEN-`MMU_PAGE_BITS-1:0] vpn;
    logic [`MMU_PLEN-`MMU_PAGE_BITS-1:0] ppn;
    logic                                megapage;
    logic                                readable;
    logic                                writable;
  } tlb_entry_t;

  // Page fault report, valid for one cycle
  typedef struct packed {
    logic                 valid;
    logic [`MMU_XLEN-1:0] vaddr;
    logic                 store;
  } fault_t;

  // Controller states
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    WALK1,
    WALK0,
    ACCESS,
    RESPOND,
    FAULT
  } mmu_state_e;

endpackage

/* mmu/mmu_satp_regs.sv */
`timescale 1ns/1ns
`include "mmu_defines.svh"

module mmu_satp_regs (
  input  logic                 clk_i,
  input  logic                 rst_i,
  // Wishbone classic slave
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  logic [3:0]           wb_adr_i,
  input  logic [`MMU_XLEN-1:0] wb_dat_i,
  output logic [`MMU_XLEN-1:0] wb_dat_o,
  output logic                 wb_ack_o,
  // To and from the translation logic
  output mmu_pkg::satp_t       satp_o,
  output logic                 flush_o,
  input  mmu_pkg::fault_t      fault_i
);

  // Word offsets, selected by adr[3:2]
  localparam logic [1:0] REG_SATP        = 2'd0;
  localparam logic [1:0] REG_FLUSH       = 2'd1;
  localparam logic [1:0] REG_FAULT_ADDR  = 2'd2;
  localparam logic [1:0] REG_FAULT_CAUSE = 2'd3;

  logic                 access;
  logic                 wr;
  logic [`MMU_XLEN-1:0] fault_addr_q;
  // bit 0 load, bit 1 store
  logic [1:0]           fault_cause_q;

  // New cycle only while no ack is out
  assign access = wb_cyc_i && wb_stb_i && !wb_ack_o;
  assign wr     = access && wb_we_i;

  //////////////////////////////////////////////////
  // Bus handshake and read data
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      wb_ack_o <= 1'b0;
      flush_o  <= 1'b0;
    end
    else
    begin
      wb_ack_o <= access;
      // satp write also drops all cached translations
      flush_o  <= wr && (wb_adr_i[3:2] == REG_SATP || wb_adr_i[3:2] == REG_FLUSH);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (access)
      case (wb_adr_i[3:2])
        REG_SATP:        wb_dat_o <= satp_o;
        REG_FAULT_ADDR:  wb_dat_o <= fault_addr_q;
        REG_FAULT_CAUSE: wb_dat_o <= {{(`MMU_XLEN-2){1'b0}}, fault_cause_q};
        // FLUSH reads as zero
        default:         wb_dat_o <= '0;
      endcase
  end

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      satp_o        <= '0;
      fault_cause_q <= '0;
    end
    else
    begin
      if (wr && wb_adr_i[3:2] == REG_SATP)
        satp_o <= mmu_pkg::satp_t'(wb_dat_i);
      // A new fault beats a clearing write
      if (fault_i.valid)
        fault_cause_q <= {fault_i.store, !fault_i.store};
      else if (wr && wb_adr_i[3:2] == REG_FAULT_CAUSE)
        fault_cause_q <= '0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (fault_i.valid)
      fault_addr_q <= fault_i.vaddr;
  end

  // Single cycle ack per access
  a_ack_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    wb_ack_o |=> !wb_ack_o);

endmodule

/* mmu/mmu_tlb.sv */
`timescale 1ns/1ns
`include "mmu_defines.svh"

module mmu_tlb (
  input  logic                                clk_i,
  input  logic                                rst_i,
  // Lookup, answered in the same cycle
  input  logic [`MMU_XLEN-`MMU_PAGE_BITS-1:0] vpn_i,
  output logic                                hit_o,
  output mmu_pkg::tlb_entry_t                 entry_o,
  // Refill from the walker
  input  logic                                fill_i,
  input  mmu_pkg::tlb_entry_t                 fill_entry_i,
  input  logic                                flush_i
);

  localparam int N     = `MMU_TLB_ENTRIES;
  localparam int PTR_W = (N > 1) ? $clog2(N) : 1;

  // Valid bits apart from payload
  logic [N-1:0]        valid_q;
  mmu_pkg::tlb_entry_t tlb_q [N];
  logic [N-1:0]        match;
  logic [PTR_W-1:0]    fill_ptr_q;

  //////////////////////////////////////////////////
  // Match
  //////////////////////////////////////////////////

  // Megapage compares vpn1 only
  always_comb
  begin
    for (int i = 0; i < N; i++)
    begin
      if (tlb_q[i].megapage)
        match[i] = valid_q[i] && (tlb_q[i].vpn[19:10] == vpn_i[19:10]);
      else
        match[i] = valid_q[i] && (tlb_q[i].vpn == vpn_i);
    end
  end

  assign hit_o = |match;

  // At most one match, so a plain OR-style select is enough
  always_comb
  begin
    entry_o = '0;
    for (int i = 0; i < N; i++)
    begin
      if (match[i])
        entry_o = tlb_q[i];
    end
    entry_o.valid = hit_o;
  end

  //////////////////////////////////////////////////
  // Refill and flush
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      valid_q    <= '0;
      fill_ptr_q <= '0;
    end
    // Flush wins over a late refill
    else if (flush_i)
      valid_q <= '0;
    else if (fill_i)
    begin
      valid_q[fill_ptr_q] <= 1'b1;
      // Round robin, wraps at N
      if (fill_ptr_q == PTR_W'(N - 1))
        fill_ptr_q <= '0;
      else
        fill_ptr_q <= fill_ptr_q + 1'b1;
    end
  end

  // Payload array
  always_ff @(posedge clk_i)
  begin
    if (fill_i)
      tlb_q[fill_ptr_q] <= fill_entry_i;
  end

  // Overlapping entries would make the select ambiguous
  a_onehot_hit: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(match));

endmodule

/* mmu/riscv_mmu.sv */
`timescale 1ns/1ns
`include "mmu_defines.svh"

module riscv_mmu (
  input  logic                                clk_i,
  input  logic                                rst_i,
  // CPU side
  input  logic                                vm_req_i,
  input  mmu_pkg::vm_req_t                    vm_i,
  output logic [`MMU_XLEN-1:0]                vm_q_o,
  output logic                                vm_ack_o,
  output logic                                vm_fault_o,
  // Memory side, carries data and PTE reads
  output logic                                pm_req_o,
  output mmu_pkg::pm_req_t                    pm_o,
  input  logic [`MMU_XLEN-1:0]                pm_q_i,
  input  logic                                pm_ack_i,
  // Translation control
  input  mmu_pkg::satp_t                      satp_i,
  output logic [`MMU_XLEN-`MMU_PAGE_BITS-1:0] tlb_vpn_o,
  input  logic                                tlb_hit_i,
  input  mmu_pkg::tlb_entry_t                 tlb_entry_i,
  output logic                                tlb_fill_o,
  output mmu_pkg::tlb_entry_t                 tlb_fill_entry_o,
  output mmu_pkg::fault_t                     fault_o
);

  localparam int PAD_W = `MMU_PLEN - `MMU_XLEN;

  mmu_pkg::mmu_state_e state_q, state_nxt;
  mmu_pkg::vm_req_t    req_q;
  mmu_pkg::pm_req_t    pm_q, pm_nxt;
  logic                pm_load;
  mmu_pkg::pte_t       pte;
  logic                pte_bad, pte_leaf, pte_perm, hit_perm;

  // Page or megapage address from a cached translation
  function automatic logic [`MMU_PLEN-1:0] phys_adr(input mmu_pkg::tlb_entry_t e,
                                                    input logic [`MMU_XLEN-1:0] va);
    if (e.megapage)
      return {e.ppn[21:10], va[21:0]};
    return {e.ppn, va[`MMU_PAGE_BITS-1:0]};
  endfunction

  function automatic mmu_pkg::pm_req_t data_req(input mmu_pkg::vm_req_t r,
                                                input logic [`MMU_PLEN-1:0] pa);
    mmu_pkg::pm_req_t p;
    p.adr  = pa;
    p.size = r.size;
    p.lock = r.lock;
    p.we   = r.we;
    p.d    = r.d;
    return p;
  endfunction

  // PTE fetch: plain word read
  function automatic mmu_pkg::pm_req_t pte_req(input logic [`MMU_PLEN-1:0] pa);
    mmu_pkg::pm_req_t p;
    p      = '0;
    p.adr  = pa;
    p.size = mmu_pkg::SIZE_WORD;
    return p;
  endfunction

  //////////////////////////////////////////////////
  // PTE decode and permission checks
  //////////////////////////////////////////////////

  assign pte      = mmu_pkg::pte_t'(pm_q_i);
  // Invalid, or the reserved W without R
  assign pte_bad  = !pte.v || (pte.w && !pte.r);
  assign pte_leaf = pte.r || pte.x;
  // No A/D update here, so clear A or clear D on store faults
  assign pte_perm = pte.a && (req_q.we ? (pte.w && pte.d) : pte.r);
  assign hit_perm = req_q.we ? tlb_entry_i.writable : tlb_entry_i.readable;

  // Refill built straight from the returning PTE
  assign tlb_vpn_o        = req_q.adr[31:12];
  assign tlb_fill_entry_o = '{valid: 1'b1, vpn: req_q.adr[31:12], ppn: {pte.ppn1, pte.ppn0},
                              megapage: state_q == mmu_pkg::WALK1, readable: pte.r,
                              writable: pte.w && pte.d};

  //////////////////////////////////////////////////
  // Controller FSM
  //////////////////////////////////////////////////

  always_comb
  begin
    state_nxt  = state_q;
    pm_load    = 1'b0;
    pm_nxt     = pm_q;
    tlb_fill_o = 1'b0;
    case (state_q)
      mmu_pkg::IDLE:
        // Bare mode goes straight out, zero extended
        if (vm_req_i && !satp_i.mode)
        begin
          state_nxt = mmu_pkg::ACCESS;
          pm_load   = 1'b1;
          pm_nxt    = data_req(vm_i, {{PAD_W{1'b0}}, vm_i.adr});
        end
        else if (vm_req_i)
          state_nxt = mmu_pkg::LOOKUP;
      mmu_pkg::LOOKUP:
        if (!tlb_hit_i)
        begin
          // Level 1 PTE at satp.ppn*4096 + vpn1*4
          state_nxt = mmu_pkg::WALK1;
          pm_load   = 1'b1;
          pm_nxt    = pte_req({satp_i.ppn, req_q.adr[31:22], 2'b00});
        end
        else if (hit_perm)
        begin
          state_nxt = mmu_pkg::ACCESS;
          pm_load   = 1'b1;
          pm_nxt    = data_req(req_q, phys_adr(tlb_entry_i, req_q.adr));
        end
        else
          state_nxt = mmu_pkg::FAULT;
      mmu_pkg::WALK1:
        if (pm_ack_i)
        begin
          if (pte_bad)
            state_nxt = mmu_pkg::FAULT;
          else if (!pte_leaf)
          begin
            // Pointer to the level 0 table
            state_nxt = mmu_pkg::WALK0;
            pm_load   = 1'b1;
            pm_nxt    = pte_req({pte.ppn1, pte.ppn0, req_q.adr[21:12], 2'b00});
          end
          // Misaligned megapage
          else if (pte.ppn0 != '0 || !pte_perm)
            state_nxt = mmu_pkg::FAULT;
          else
          begin
            state_nxt  = mmu_pkg::ACCESS;
            tlb_fill_o = 1'b1;
            pm_load    = 1'b1;
            pm_nxt     = data_req(req_q, phys_adr(tlb_fill_entry_o, req_q.adr));
          end
        end
      mmu_pkg::WALK0:
        if (pm_ack_i)
        begin
          // A pointer at level 0 is a fault too
          if (pte_bad || !pte_leaf || !pte_perm)
            state_nxt = mmu_pkg::FAULT;
          else
          begin
            state_nxt  = mmu_pkg::ACCESS;
            tlb_fill_o = 1'b1;
            pm_load    = 1'b1;
            pm_nxt     = data_req(req_q, phys_adr(tlb_fill_entry_o, req_q.adr));
          end
        end
      mmu_pkg::ACCESS:
        if (pm_ack_i)
          state_nxt = mmu_pkg::RESPOND;
      // Both last one cycle, ack goes out here
      mmu_pkg::RESPOND,
      mmu_pkg::FAULT:
        state_nxt = mmu_pkg::IDLE;
      default:
        state_nxt = mmu_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      state_q <= mmu_pkg::IDLE;
    else
      state_q <= state_nxt;
  end

  always_ff @(posedge clk_i)
  begin
    if (state_q == mmu_pkg::IDLE && vm_req_i)
      req_q <= vm_i;
    if (pm_load)
      pm_q <= pm_nxt;
    if (state_q == mmu_pkg::ACCESS && pm_ack_i)
      vm_q_o <= pm_q_i;
  end

  // Outputs decoded from state
  assign pm_req_o   = state_q inside {mmu_pkg::WALK1, mmu_pkg::WALK0, mmu_pkg::ACCESS};
  assign pm_o       = pm_q;
  assign vm_ack_o   = state_q inside {mmu_pkg::RESPOND, mmu_pkg::FAULT};
  assign vm_fault_o = state_q == mmu_pkg::FAULT;
  assign fault_o    = '{valid: state_q == mmu_pkg::FAULT, vaddr: req_q.adr, store: req_q.we};

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  // Memory request held until acknowledged
  a_pm_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    pm_req_o && !pm_ack_i |=> pm_req_o && $stable(pm_o));

  // Faulting ack comes with no data access just finished
  a_fault_ack: assert property (@(posedge clk_i) disable iff (rst_i)
    vm_fault_o |-> vm_ack_o && !$past(pm_req_o && pm_ack_i && state_q == mmu_pkg::ACCESS));

  // Refill only from a finished walk, and visible in the TLB next cycle
  a_fill_walk: assert property (@(posedge clk_i) disable iff (rst_i)
    tlb_fill_o |-> state_q inside {mmu_pkg::WALK1, mmu_pkg::WALK0} ##1 tlb_hit_i);

endmodule

/* project.f */
+incdir+common
common/mmu_pkg.sv
mmu/mmu_tlb.sv
mmu/mmu_satp_regs.sv
mmu/riscv_mmu.sv
src/mmu_top.sv
verif/tb_mem_model.sv
verif/tb_mmu_top.sv

/* src/mmu_top.sv */
`timescale 1ns/1ns
`include "mmu_defines.svh"

module mmu_top (
  input  logic                 clk_i,
  input  logic                 rst_i,
  // CPU load/store port
  input  logic                 vm_req_i,
  input  mmu_pkg::vm_req_t     vm_i,
  output logic [`MMU_XLEN-1:0] vm_q_o,
  output logic                 vm_ack_o,
  output logic                 vm_fault_o,
  // Memory port
  output logic                 pm_req_o,
  output mmu_pkg::pm_req_t     pm_o,
  input  logic [`MMU_XLEN-1:0] pm_q_i,
  input  logic                 pm_ack_i,
  // Wishbone config port
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  logic [3:0]           wb_adr_i,
  input  logic [`MMU_XLEN-1:0] wb_dat_i,
  output logic [`MMU_XLEN-1:0] wb_dat_o,
  output logic                 wb_ack_o
);

  mmu_pkg::satp_t                      satp;
  logic                                flush;
  mmu_pkg::fault_t                     fault;
  // Controller to TLB
  logic [`MMU_XLEN-`MMU_PAGE_BITS-1:0] tlb_vpn;
  logic                                tlb_hit;
  mmu_pkg::tlb_entry_t                 tlb_entry;
  logic                                tlb_fill;
  mmu_pkg::tlb_entry_t                 tlb_fill_entry;

  riscv_mmu riscv_mmu_inst (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .vm_req_i         (vm_req_i),
    .vm_i             (vm_i),
    .vm_q_o           (vm_q_o),
    .vm_ack_o         (vm_ack_o),
    .vm_fault_o       (vm_fault_o),
    .pm_req_o         (pm_req_o),
    .pm_o             (pm_o),
    .pm_q_i           (pm_q_i),
    .pm_ack_i         (pm_ack_i),
    .satp_i           (satp),
    .tlb_vpn_o        (tlb_vpn),
    .tlb_hit_i        (tlb_hit),
    .tlb_entry_i      (tlb_entry),
    .tlb_fill_o       (tlb_fill),
    .tlb_fill_entry_o (tlb_fill_entry),
    .fault_o          (fault)
  );

  mmu_tlb mmu_tlb_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .vpn_i        (tlb_vpn),
    .hit_o        (tlb_hit),
    .entry_o      (tlb_entry),
    .fill_i       (tlb_fill),
    .fill_entry_i (tlb_fill_entry),
    .flush_i      (flush)
  );

  mmu_satp_regs mmu_satp_regs_inst (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .satp_o   (satp),
    .flush_o  (flush),
    .fault_i  (fault)
  );

endmodule

/* verif/tb_mem_model.sv */
`timescale 1ns/1ns
`include "mmu_defines.svh"

module tb_mem_model (
  input  logic                 clk_i,
  input  logic                 rst_i,
  // Memory port of the DUT
  input  logic                 pm_req_i,
  input  mmu_pkg::pm_req_t     pm_i,
  output logic [`MMU_XLEN-1:0] pm_q_o,
  output logic                 pm_ack_o,
  // Backdoor load from the testbench
  input  logic                 load_i,
  input  logic [`MMU_PLEN-1:0] load_adr_i,
  input  logic [`MMU_XLEN-1:0] load_dat_i
);

  // 64 KiB window, higher address bits alias
  localparam int WORDS = 16384;

  logic [`MMU_XLEN-1:0] mem [WORDS];
  logic                 wait_q;

  // Fill pattern from the whole word index
  initial
  begin
    for (int i = 0; i < WORDS; i++)
      mem[i] = 32'(i) * 32'h9E37_79B9 ^ 32'h5A5A_A5A5;
  end

  // Ack two cycles after the request is seen, word accesses only
  always @(posedge clk_i)
  begin
    if (load_i)
      mem[load_adr_i[15:2]] = load_dat_i;
    if (rst_i)
    begin
      wait_q   <= 1'b0;
      pm_ack_o <= 1'b0;
    end
    else
    begin
      pm_ack_o <= 1'b0;
      if (pm_req_i && !pm_ack_o)
      begin
        if (wait_q)
        begin
          wait_q   <= 1'b0;
          pm_ack_o <= 1'b1;
          pm_q_o   <= mem[pm_i.adr[15:2]];
          if (pm_i.we)
            mem[pm_i.adr[15:2]] = pm_i.d;
        end
        else
          wait_q <= 1'b1;
      end
    end
  end

endmodule

/* verif/tb_mmu_top.sv */
`timescale 1ns/1ns
`include "mmu_defines.svh"

module tb_mmu_top;

  logic                 clk, rst;
  logic                 vm_req, vm_ack, vm_fault;
  mmu_pkg::vm_req_t     vm;
  logic [`MMU_XLEN-1:0] vm_q, pm_q;
  logic                 pm_req, pm_ack;
  mmu_pkg::pm_req_t     pm;
  logic                 wb_cyc, wb_stb, wb_we, wb_ack;
  logic [3:0]           wb_adr;
  logic [`MMU_XLEN-1:0] wb_wdat, wb_rdat;
  logic                 load;
  logic [`MMU_PLEN-1:0] load_adr;
  logic [`MMU_XLEN-1:0] load_dat;
  // Own copy of whatever was loaded, same aliasing as the model
  logic [31:0]          shadow [16384];
  logic [21:0]          root_ppn;
  logic [31:0]          lcg_state = 32'd36;
  mmu_pkg::pm_req_t     pm_log [$];
  string                test_name;
  int                   errors, errors_at_start, tests_run, tests_failed;

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  mmu_top mmu_top_inst (
    .clk_i (clk), .rst_i (rst),
    .vm_req_i (vm_req), .vm_i (vm), .vm_q_o (vm_q), .vm_ack_o (vm_ack), .vm_fault_o (vm_fault),
    .pm_req_o (pm_req), .pm_o (pm), .pm_q_i (pm_q), .pm_ack_i (pm_ack),
    .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb), .wb_we_i (wb_we), .wb_adr_i (wb_adr),
    .wb_dat_i (wb_wdat), .wb_dat_o (wb_rdat), .wb_ack_o (wb_ack)
  );

  tb_mem_model mem_model_inst (
    .clk_i (clk), .rst_i (rst), .pm_req_i (pm_req), .pm_i (pm), .pm_q_o (pm_q),
    .pm_ack_o (pm_ack), .load_i (load), .load_adr_i (load_adr), .load_dat_i (load_dat)
  );

  // Every completed memory request, cleared per CPU access
  always @(negedge clk)
  begin
    if (pm_ack)
      pm_log.push_back(pm);
  end

  a_wb_one_cycle: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
    else
    begin
      errors++;
      $display("Wishbone acknowledge stayed high for two cycles");
    end

  a_ack_with_req: assert property (@(posedge clk) disable iff (rst) vm_ack |-> vm_req)
    else
    begin
      errors++;
      $display("CPU acknowledge without a pending request");
    end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Flags are D A G U X W R V from bit 7 down
  function automatic logic [31:0] make_pte(input logic [21:0] ppn, input logic [7:0] flags);
    return {ppn, 2'b00, flags};
  endfunction

  // Sv32 walk over the shadow tables
  function automatic void walk_tables(input logic [31:0] va, input logic store,
                                      output logic [33:0] pa, output int reads,
                                      output logic fault);
    mmu_pkg::pte_t pte;
    logic [33:0]   base;
    logic [33:0]   adr;
    logic [9:0]    idx;
    base  = {root_ppn, 12'h000};
    pa    = '0;
    reads = 0;
    fault = 1'b1;
    for (int lvl = 1; lvl >= 0; lvl--)
    begin
      idx = (lvl == 1) ? va[31:22] : va[21:12];
      adr = base + {22'b0, idx, 2'b00};
      pte = mmu_pkg::pte_t'(shadow[adr[15:2]]);
      reads++;
      if (!pte.v || (pte.w && !pte.r))
        return;
      if (pte.r || pte.x)
      begin
        // Leaf: A set, R for loads, W and D for stores
        if (!pte.a || (store ? !(pte.w && pte.d) : !pte.r))
          return;
        if (lvl == 1 && pte.ppn0 != 10'h0)
          return;
        pa    = (lvl == 1) ? {pte.ppn1, va[21:0]} : {pte.ppn1, pte.ppn0, va[11:0]};
        fault = 1'b0;
        return;
      end
      base = {pte.ppn1, pte.ppn0, 12'h000};
    end
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $finish;
  endtask

  task automatic check_equal(input string what, input logic [33:0] exp, input logic [33:0] act);
    assert (exp === act)
    else
    begin
      errors++;
      $display("FAIL %s %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  // Request count, and the data address as the last request
  task automatic check_data_req(input logic [33:0] exp_pa, input int count);
    check_equal("pm requests", 34'(count), 34'(pm_log.size()));
    if (pm_log.size() > 0)
      check_equal("data address", exp_pa, pm_log[$].adr);
  endtask

  task automatic poke_word(input logic [33:0] pa, input logic [31:0] data);
    @(posedge clk);
    load     <= 1'b1;
    load_adr <= pa;
    load_dat <= data;
    @(posedge clk);
    load            <= 1'b0;
    shadow[pa[15:2]] = data;
  endtask

  task automatic wb_access(input logic we, input logic [3:0] adr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    int t;
    @(posedge clk);
    wb_cyc  <= 1'b1;
    wb_stb  <= 1'b1;
    wb_we   <= we;
    wb_adr  <= adr;
    wb_wdat <= wdata;
    t = 0;
    do
    begin
      @(negedge clk);
      t++;
      if (t > 20)
        abort_run("Wishbone access got no acknowledge");
    end
    while (!wb_ack);
    rdata = wb_rdat;
    // Sampled one cycle after the slave saw cyc and stb
    check_equal("wb ack latency", 34'd2, 34'(t));
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    @(negedge clk);
    check_equal("wb ack after drop", 34'd0, 34'(wb_ack));
  endtask

  task automatic cpu_access(input logic we, input logic [31:0] va, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic fault);
    int t;
    pm_log.delete();
    @(posedge clk);
    vm_req <= 1'b1;
    vm     <= '{adr: va, size: mmu_pkg::SIZE_WORD, lock: 1'b0, we: we, d: wdata};
    t = 0;
    do
    begin
      @(negedge clk);
      t++;
      if (t > 200)
        abort_run("CPU access got no acknowledge");
    end
    while (!vm_ack);
    rdata = vm_q;
    fault = vm_fault;
    @(posedge clk);
    vm_req <= 1'b0;
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = errors;
  endtask

  task automatic finish_test();
    tests_run++;
    if (errors == errors_at_start)
      $display("%s: passed", test_name);
    else
    begin
      tests_failed++;
      $display("%s: failed", test_name);
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial
  begin
    logic [31:0] va, wdata, rdata;
    logic [33:0] pa, pa_old;
    logic        fault, exp_fault;
    int          reads;
    rst     = 1'b1;
    vm_req  = 1'b0;
    vm      = '0;
    wb_cyc  = 1'b0;
    wb_stb  = 1'b0;
    wb_we   = 1'b0;
    wb_adr  = '0;
    wb_wdat = '0;
    load    = 1'b0;
    load_adr = '0;
    load_dat = '0;
    errors  = 0;
    tests_run = 0;
    tests_failed = 0;
    root_ppn = 22'h1;
    for (int i = 0; i < 16384; i++)
      shadow[i] = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    // Bare mode, random high address bits
    start_test("bare");
    va    = (next_rand() & 32'hFFFF_7FFC) | 32'h0000_8000;
    wdata = next_rand();
    cpu_access(1'b1, va, wdata, rdata, fault);
    check_equal("store fault", 34'd0, 34'(fault));
    check_data_req({2'b00, va}, 1);
    cpu_access(1'b0, va, 32'h0, rdata, fault);
    check_data_req({2'b00, va}, 1);
    check_equal("load data", 34'(wdata), 34'(rdata));
    finish_test();

    // Root at 0x1000, level 0 table at 0x2000
    poke_word(34'h1100, make_pte(22'h2, 8'h01));
    poke_word(34'h2044, make_pte(22'h3, 8'hC7));
    poke_word(34'h2048, make_pte(22'h4, 8'h43));
    poke_word(34'h1140, 32'h0);
    poke_word(34'h1180, make_pte({12'h123, 10'h0}, 8'hC7));

    start_test("page 4k");
    wb_access(1'b1, 4'h0, {1'b1, 9'h0, root_ppn}, rdata);
    va = 32'h1001_1000 | (next_rand() & 32'h0000_0FFC);
    walk_tables(va, 1'b0, pa, reads, exp_fault);
    poke_word(pa, next_rand());
    cpu_access(1'b0, va, 32'h0, rdata, fault);
    check_equal("fault", 34'(exp_fault), 34'(fault));
    check_data_req(pa, reads + 1);
    check_equal("load data", 34'(shadow[pa[15:2]]), 34'(rdata));
    finish_test();

    start_test("megapage");
    va = 32'h1800_A000 | (next_rand() & 32'h0000_0FFC);
    walk_tables(va, 1'b0, pa, reads, exp_fault);
    poke_word(pa, next_rand());
    cpu_access(1'b0, va, 32'h0, rdata, fault);
    check_equal("fault", 34'(exp_fault), 34'(fault));
    check_data_req(pa, reads + 1);
    check_equal("load data", 34'(shadow[pa[15:2]]), 34'(rdata));
    finish_test();

    // Cached page, then a remap seen only after FLUSH
    start_test("tlb hit");
    va = 32'h1001_1000 | (next_rand() & 32'h0000_0FFC);
    walk_tables(va, 1'b0, pa_old, reads, exp_fault);
    poke_word(pa_old, next_rand());
    cpu_access(1'b0, va, 32'h0, rdata, fault);
    check_data_req(pa_old, 1);
    check_equal("load data", 34'(shadow[pa_old[15:2]]), 34'(rdata));
    poke_word(34'h2044, make_pte(22'h5, 8'hC7));
    walk_tables(va, 1'b0, pa, reads, exp_fault);
    poke_word(pa, next_rand());
    cpu_access(1'b0, va, 32'h0, rdata, fault);
    check_data_req(pa_old, 1);
    wb_access(1'b1, 4'h4, next_rand(), rdata);
    cpu_access(1'b0, va, 32'h0, rdata, fault);
    check_data_req(pa, reads + 1);
    check_equal("load data", 34'(shadow[pa[15:2]]), 34'(rdata));
    finish_test();

    start_test("page fault");
    va = 32'h1400_0000 | (next_rand() & 32'h003F_FFFC);
    walk_tables(va, 1'b0, pa, reads, exp_fault);
    cpu_access(1'b0, va, 32'h0, rdata, fault);
    check_equal("load fault", 34'(exp_fault), 34'(fault));
    check_equal("pm requests", 34'(reads), 34'(pm_log.size()));
    wb_access(1'b0, 4'h8, 32'h0, rdata);
    check_equal("fault addr", 34'(va), 34'(rdata));
    wb_access(1'b0, 4'hC, 32'h0, rdata);
    check_equal("fault cause", 34'h1, 34'(rdata));
    // Store to a read-only page faults at level 0
    va    = 32'h1001_2000 | (next_rand() & 32'h0000_0FFC);
    wdata = next_rand();
    walk_tables(va, 1'b1, pa, reads, exp_fault);
    cpu_access(1'b1, va, wdata, rdata, fault);
    check_equal("store fault", 34'(exp_fault), 34'(fault));
    check_equal("pm requests", 34'(reads), 34'(pm_log.size()));
    wb_access(1'b0, 4'h8, 32'h0, rdata);
    check_equal("fault addr", 34'(va), 34'(rdata));
    wb_access(1'b0, 4'hC, 32'h0, rdata);
    check_equal("fault cause", 34'h2, 34'(rdata));
    wb_access(1'b1, 4'hC, next_rand(), rdata);
    wb_access(1'b0, 4'hC, 32'h0, rdata);
    check_equal("cleared cause", 34'h0, 34'(rdata));
    finish_test();

    start_test("registers");
    wdata = next_rand();
    wb_access(1'b1, 4'h0, wdata, rdata);
    wb_access(1'b0, 4'h0, 32'h0, rdata);
    check_equal("satp", 34'(wdata), 34'(rdata));
    finish_test();

    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule
